// ==== Bender.yml ====
package:
  name: hyper_front

sources:
  - source/hyper_front_pkg.sv
  - source/ax_arbiter.sv
  - source/ax_translate.sv
  - source/w_buffer.sv
  - source/trans_tracker.sv
  - source/hyper_front.sv
  - target: test
    files:
      - tests/tb_hyper_front.sv

// ==== all.f ====
source/hyper_front_pkg.sv
source/ax_arbiter.sv
source/ax_translate.sv
source/w_buffer.sv
source/trans_tracker.sv
source/hyper_front.sv
tests/tb_hyper_front.sv

// ==== source/ax_arbiter.sv ====
`timescale 1ns/1ps

module ax_arbiter import hyper_front_pkg::*; (
    input  logic   clk_i,
    input  logic   rst_ni,
    // AR channel
    input  logic   ar_valid_i,
    output logic   ar_ready_o,
    input  addr_t  ar_addr_i,
    input  len_t   ar_len_i,
    input  size_t  ar_size_i,
    input  burst_t ar_burst_i,
    // AW channel
    input  logic   aw_valid_i,
    output logic   aw_ready_o,
    input  addr_t  aw_addr_i,
    input  len_t   aw_len_i,
    input  size_t  aw_size_i,
    input  burst_t aw_burst_i,
    // Held request
    output logic   ax_valid_o,
    input  logic   ax_ready_i,
    output addr_t  ax_addr_o,
    output len_t   ax_len_o,
    output size_t  ax_size_o,
    output burst_t ax_burst_o,
    output logic   ax_write_o
);

    logic   sel_valid, sel_write, spill_ready;
    addr_t  sel_addr;
    len_t   sel_len;
    size_t  sel_size;
    burst_t sel_burst;

    logic   init_done_q;
    logic   a_full_q, b_full_q;
    logic   a_fill, a_drain, b_fill, b_drain;
    addr_t  a_addr_q, b_addr_q;
    len_t   a_len_q, b_len_q;
    size_t  a_size_q, b_size_q;
    burst_t a_burst_q, b_burst_q;
    logic   a_write_q, b_write_q;

    // ======================================
    // Fixed priority, reads first
    // ======================================

    assign sel_valid = ar_valid_i | aw_valid_i;
    assign sel_write = ~ar_valid_i;
    assign sel_addr  = ar_valid_i ? ar_addr_i  : aw_addr_i;
    assign sel_len   = ar_valid_i ? ar_len_i   : aw_len_i;
    assign sel_size  = ar_valid_i ? ar_size_i  : aw_size_i;
    assign sel_burst = ar_valid_i ? ar_burst_i : aw_burst_i;

    assign ar_ready_o = spill_ready;
    assign aw_ready_o = spill_ready & ~ar_valid_i;

    // ======================================
    // Spill register
    // ======================================

    // Not ready until the first cycle out of reset
    assign spill_ready = init_done_q & (~a_full_q | ~b_full_q);

    assign a_fill  = sel_valid & spill_ready;
    assign a_drain = a_full_q & ~b_full_q;
    // Entry A moves to B when the consumer stalls
    assign b_fill  = a_drain & ~ax_ready_i;
    assign b_drain = b_full_q & ax_ready_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            init_done_q <= 1'b0;
            a_full_q    <= 1'b0;
            b_full_q    <= 1'b0;
        end else begin
            init_done_q <= 1'b1;
            if (a_fill || a_drain) begin
                a_full_q <= a_fill;
            end
            if (b_fill || b_drain) begin
                b_full_q <= b_fill;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (a_fill) begin
            a_addr_q  <= sel_addr;
            a_len_q   <= sel_len;
            a_size_q  <= sel_size;
            a_burst_q <= sel_burst;
            a_write_q <= sel_write;
        end
        if (b_fill) begin
            b_addr_q  <= a_addr_q;
            b_len_q   <= a_len_q;
            b_size_q  <= a_size_q;
            b_burst_q <= a_burst_q;
            b_write_q <= a_write_q;
        end
    end

    // B holds the older request when full
    assign ax_valid_o = a_full_q | b_full_q;
    assign ax_addr_o  = b_full_q ? b_addr_q  : a_addr_q;
    assign ax_len_o   = b_full_q ? b_len_q   : a_len_q;
    assign ax_size_o  = b_full_q ? b_size_q  : a_size_q;
    assign ax_burst_o = b_full_q ? b_burst_q : a_burst_q;
    assign ax_write_o = b_full_q ? b_write_q : a_write_q;

    // Master keeps a stalled request unchanged
    ar_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        ar_valid_i && !ar_ready_o |=>
            ar_valid_i && $stable({ar_addr_i, ar_len_i, ar_size_i, ar_burst_i}))
        else $error("AR request changed while stalled");

    aw_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        aw_valid_i && !aw_ready_o |=>
            aw_valid_i && $stable({aw_addr_i, aw_len_i, aw_size_i, aw_burst_i}))
        else $error("AW request changed while stalled");

endmodule

// ==== source/ax_translate.sv ====
`timescale 1ns/1ps

module ax_translate import hyper_front_pkg::*; (
    input  addr_t      ax_addr_i,
    input  len_t       ax_len_i,
    input  size_t      ax_size_i,
    input  logic [4:0] addr_mask_msb_i,
    output addr_t      trans_addr_o,
    output blen_t      trans_burst_o,
    output cs_t        trans_cs_o
);

    addr_t addr_mask;
    logic  chip_bit;

    // ======================================
    // Address masking
    // ======================================

    // Keep only the bits below the mask msb
    assign addr_mask = ~(addr_t'('1) << addr_mask_msb_i);

    // Byte address to 16-bit word address
    assign trans_addr_o = (ax_addr_i & addr_mask) >> 1;

    // ======================================
    // Chip select
    // ======================================

    // The chip is picked by the first bit above the mask
    assign chip_bit = ax_addr_i[addr_mask_msb_i];

    always_comb begin
        trans_cs_o = '0;
        trans_cs_o[chip_bit] = 1'b1;
    end

    // ======================================
    // Burst length
    // ======================================

    // AXI beats minus one, converted to whole 16-bit words
    always_comb begin
        if (ax_size_i == size_t'(0)) begin
            // Byte beats, an odd start address adds one byte in front
            trans_burst_o = ((blen_t'(ax_addr_i[0]) + blen_t'(ax_len_i)) >> 1) + blen_t'(1);
        end else begin
            // One word per beat
            trans_burst_o = blen_t'(ax_len_i) + blen_t'(1);
        end
    end

endmodule

// ==== source/hyper_front.sv ====
`timescale 1ns/1ps

module hyper_front import hyper_front_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_ni,
    // AR channel
    input  logic       ar_valid_i,
    output logic       ar_ready_o,
    input  addr_t      ar_addr_i,
    input  len_t       ar_len_i,
    input  size_t      ar_size_i,
    input  burst_t     ar_burst_i,
    // AW channel
    input  logic       aw_valid_i,
    output logic       aw_ready_o,
    input  addr_t      aw_addr_i,
    input  len_t       aw_len_i,
    input  size_t      aw_size_i,
    input  burst_t     aw_burst_i,
    // W channel
    input  logic       w_valid_i,
    output logic       w_ready_o,
    input  word_t      w_data_i,
    input  strb_t      w_strb_i,
    input  logic       w_last_i,
    // R channel
    output logic       r_valid_o,
    input  logic       r_ready_i,
    output word_t      r_data_o,
    output logic       r_last_o,
    output resp_t      r_resp_o,
    // B channel
    output logic       b_valid_o,
    input  logic       b_ready_i,
    output resp_t      b_resp_o,
    // Transfer descriptor
    output logic       trans_valid_o,
    input  logic       trans_ready_i,
    output logic       trans_write_o,
    output addr_t      trans_addr_o,
    output blen_t      trans_burst_o,
    output cs_t        trans_cs_o,
    output logic       trans_addr_space_o,
    // PHY transmit
    output logic       tx_valid_o,
    input  logic       tx_ready_i,
    output word_t      tx_data_o,
    output strb_t      tx_strb_o,
    output logic       tx_last_o,
    // PHY receive
    input  logic       rx_valid_i,
    output logic       rx_ready_o,
    input  word_t      rx_data_i,
    input  logic       rx_last_i,
    input  logic       rx_error_i,
    // PHY write response
    input  logic       b_phy_valid_i,
    output logic       b_phy_ready_o,
    input  logic       b_error_i,
    // Configuration and status
    input  logic [4:0] addr_mask_msb_i,
    input  logic       addr_space_i,
    output logic       trans_active_o
);

    logic   ax_valid, ax_ready, ax_write;
    addr_t  ax_addr;
    len_t   ax_len;
    size_t  ax_size;
    burst_t ax_burst;

    logic   buf_valid, buf_ready, buf_last;
    logic   rx_done, b_done;

    // ======================================
    // Request path
    // ======================================

    ax_arbiter ax_arbiter_inst (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .ar_valid_i (ar_valid_i),
        .ar_ready_o (ar_ready_o),
        .ar_addr_i  (ar_addr_i),
        .ar_len_i   (ar_len_i),
        .ar_size_i  (ar_size_i),
        .ar_burst_i (ar_burst_i),
        .aw_valid_i (aw_valid_i),
        .aw_ready_o (aw_ready_o),
        .aw_addr_i  (aw_addr_i),
        .aw_len_i   (aw_len_i),
        .aw_size_i  (aw_size_i),
        .aw_burst_i (aw_burst_i),
        .ax_valid_o (ax_valid),
        .ax_ready_i (ax_ready),
        .ax_addr_o  (ax_addr),
        .ax_len_o   (ax_len),
        .ax_size_o  (ax_size),
        .ax_burst_o (ax_burst),
        .ax_write_o (ax_write)
    );

    ax_translate ax_translate_inst (
        .ax_addr_i       (ax_addr),
        .ax_len_i        (ax_len),
        .ax_size_i       (ax_size),
        .addr_mask_msb_i (addr_mask_msb_i),
        .trans_addr_o    (trans_addr_o),
        .trans_burst_o   (trans_burst_o),
        .trans_cs_o      (trans_cs_o)
    );

    assign trans_write_o      = ax_write;
    assign trans_addr_space_o = addr_space_i;

    // ======================================
    // W path
    // ======================================

    w_buffer w_buffer_inst (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .w_valid_i   (w_valid_i),
        .w_ready_o   (w_ready_o),
        .w_data_i    (w_data_i),
        .w_strb_i    (w_strb_i),
        .w_last_i    (w_last_i),
        .buf_valid_o (buf_valid),
        .buf_ready_i (buf_ready),
        .buf_data_o  (tx_data_o),
        .buf_strb_o  (tx_strb_o),
        .buf_last_o  (buf_last)
    );

    assign tx_last_o = buf_last;

    // ======================================
    // R and B passthrough
    // ======================================

    assign r_valid_o  = rx_valid_i;
    assign r_data_o   = rx_data_i;
    assign r_last_o   = rx_last_i;
    assign r_resp_o   = rx_error_i ? RespSlvErr : RespOkay;
    assign rx_ready_o = r_ready_i;

    assign b_valid_o     = b_phy_valid_i;
    assign b_resp_o      = b_error_i ? RespSlvErr : RespOkay;
    assign b_phy_ready_o = b_ready_i;

    // Final read beat or write response ends the transfer
    assign rx_done = rx_valid_i & r_ready_i & rx_last_i;
    assign b_done  = b_phy_valid_i & b_ready_i;

    // ======================================
    // Transfer status
    // ======================================

    trans_tracker trans_tracker_inst (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .ax_valid_i     (ax_valid),
        .ax_ready_o     (ax_ready),
        .ax_write_i     (ax_write),
        .ax_len_i       (ax_len),
        .ax_size_i      (ax_size),
        .ax_burst_i     (ax_burst),
        .ax_addr_i      (ax_addr),
        .trans_valid_o  (trans_valid_o),
        .trans_ready_i  (trans_ready_i),
        .buf_valid_i    (buf_valid),
        .buf_ready_o    (buf_ready),
        .buf_last_i     (buf_last),
        .tx_valid_o     (tx_valid_o),
        .tx_ready_i     (tx_ready_i),
        .rx_done_i      (rx_done),
        .b_done_i       (b_done),
        .trans_active_o (trans_active_o)
    );

endmodule

// ==== source/hyper_front_pkg.sv ====
package hyper_front_pkg;

    // ======================================
    // Widths and sizes
    // ======================================

    localparam int unsigned AddrWidth = 32;
    localparam int unsigned WordWidth = 16;
    localparam int unsigned StrbWidth = WordWidth / 8;
    localparam int unsigned NumChips  = 2;
    localparam int unsigned WBufDepth = 8;
    localparam int unsigned BlenWidth = 16;

    // ======================================
    // Types
    // ======================================

    typedef logic [AddrWidth-1:0] addr_t;
    typedef logic [WordWidth-1:0] word_t;
    typedef logic [StrbWidth-1:0] strb_t;

    // AXI request fields
    typedef logic [7:0] len_t;
    typedef logic [2:0] size_t;
    typedef logic [1:0] burst_t;

    // HyperBus burst length, counted in 16-bit words
    typedef logic [BlenWidth-1:0] blen_t;

    // One-hot chip selects
    typedef logic [NumChips-1:0] cs_t;

    typedef logic [1:0] resp_t;

    // ======================================
    // Encodings
    // ======================================

    localparam burst_t BurstFixed = 2'd0;
    localparam burst_t BurstIncr  = 2'd1;

    localparam resp_t RespOkay   = 2'd0;
    localparam resp_t RespSlvErr = 2'd2;

endpackage

// ==== source/trans_tracker.sv ====
`timescale 1ns/1ps

module trans_tracker import hyper_front_pkg::*; (
    input  logic   clk_i,
    input  logic   rst_ni,
    // Held request
    input  logic   ax_valid_i,
    output logic   ax_ready_o,
    input  logic   ax_write_i,
    input  len_t   ax_len_i,
    input  size_t  ax_size_i,
    input  burst_t ax_burst_i,
    input  addr_t  ax_addr_i,
    // Descriptor handshake
    output logic   trans_valid_o,
    input  logic   trans_ready_i,
    // W buffer to PHY
    input  logic   buf_valid_i,
    output logic   buf_ready_o,
    input  logic   buf_last_i,
    output logic   tx_valid_o,
    input  logic   tx_ready_i,
    // Transfer ends
    input  logic   rx_done_i,
    input  logic   b_done_i,
    output logic   trans_active_o
);

    logic active_q, engaged_q;
    logic trans_hs, tx_last_hs;

    // One transfer at a time
    assign trans_valid_o = ax_valid_i & ~active_q;
    assign ax_ready_o    = trans_ready_i & ~active_q;
    assign trans_hs      = trans_valid_o & trans_ready_i;

    // W data flows only once the write descriptor went out
    assign tx_valid_o  = buf_valid_i & engaged_q;
    assign buf_ready_o = tx_ready_i & engaged_q;
    assign tx_last_hs  = tx_valid_o & tx_ready_i & buf_last_i;

    // Set wins over clear on the same edge
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            active_q  <= 1'b0;
            engaged_q <= 1'b0;
        end else begin
            if (trans_hs) begin
                active_q <= 1'b1;
            end else if (rx_done_i || b_done_i) begin
                active_q <= 1'b0;
            end
            if (trans_hs && ax_write_i) begin
                engaged_q <= 1'b1;
            end else if (tx_last_hs) begin
                engaged_q <= 1'b0;
            end
        end
    end

    assign trans_active_o = active_q;

    // Supported request shapes
    burst_ok: assert property (@(posedge clk_i) disable iff (!rst_ni)
        trans_hs |-> (ax_burst_i == BurstIncr) ||
                     ((ax_burst_i == BurstFixed) && (ax_len_i == '0)))
        else $error("Unsupported burst type");

    size_ok: assert property (@(posedge clk_i) disable iff (!rst_ni)
        trans_hs |-> ax_size_i <= size_t'(1))
        else $error("Beat size above one word");

    align_ok: assert property (@(posedge clk_i) disable iff (!rst_ni)
        trans_hs && (ax_size_i == size_t'(1)) |-> !ax_addr_i[0])
        else $error("Word access on odd address");

endmodule

// ==== source/w_buffer.sv ====
`timescale 1ns/1ps

module w_buffer import hyper_front_pkg::*; (
    input  logic  clk_i,
    input  logic  rst_ni,
    // AXI W side
    input  logic  w_valid_i,
    output logic  w_ready_o,
    input  word_t w_data_i,
    input  strb_t w_strb_i,
    input  logic  w_last_i,
    // Buffer head
    output logic  buf_valid_o,
    input  logic  buf_ready_i,
    output word_t buf_data_o,
    output strb_t buf_strb_o,
    output logic  buf_last_o
);

    word_t data_mem [WBufDepth];
    strb_t strb_mem [WBufDepth];
    logic  last_mem [WBufDepth];

    logic [$clog2(WBufDepth)-1:0] wr_ptr_q, rd_ptr_q;
    logic [$clog2(WBufDepth):0]   count_q;
    logic push, pop, full;

    assign full      = (count_q == ($clog2(WBufDepth)+1)'(WBufDepth));
    assign w_ready_o = ~full;
    assign push      = w_valid_i & w_ready_o;
    assign pop       = buf_valid_o & buf_ready_i;

    // Pointers wrap naturally at the power of two depth
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            data_mem[wr_ptr_q] <= w_data_i;
            strb_mem[wr_ptr_q] <= w_strb_i;
            last_mem[wr_ptr_q] <= w_last_i;
        end
    end

    // Head is only visible once written, no fall-through
    assign buf_valid_o = (count_q != '0);
    assign buf_data_o  = data_mem[rd_ptr_q];
    assign buf_strb_o  = strb_mem[rd_ptr_q];
    assign buf_last_o  = last_mem[rd_ptr_q];

    no_push_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
        full && !pop |=> $stable(wr_ptr_q) && full)
        else $error("W buffer written while full");

endmodule

// ==== tests/hyper_front_golden.txt ====
# name kind addr len size mask_msb strb d0 d1 d2 d3 err exp_trans_addr exp_burst exp_cs
# all hex; words used are len+1; kind rd, wr, or rdwr (AR and AW in the same cycle)
rd_c0      rd   00000100 03 1 17 3 1111 2222 3333 4444 0 00000080 0004 1
rd_c1_err  rd   00800040 01 1 17 3 a5a5 5a5a 0000 0000 1 00000020 0002 2
rd_byte    rd   00000013 02 0 17 3 00ab 00cd 00ef 0000 0 00000009 0002 1
rd_msb16   rd   00012344 00 1 10 3 beef 0000 0000 0000 0 000011a2 0001 2
wr_c0      wr   00000200 03 1 17 3 0102 0304 0506 0708 0 00000100 0004 1
wr_c1_err  wr   00c00010 02 1 17 3 dead c0de f00d 0000 1 00200008 0003 2
wr_byte    wr   00000021 00 0 17 2 ab00 0000 0000 0000 0 00000010 0001 1
pair       rdwr 00000400 01 1 17 3 1234 5678 0000 0000 0 00000200 0002 1
wr_msb20   wr   00180006 01 1 14 3 cafe babe 0000 0000 0 00040003 0002 2
rd_top     rd   007ffffe 00 1 17 3 7fff 0000 0000 0000 0 003fffff 0001 1
pair_err   rdwr 00800002 03 1 17 3 aaaa bbbb cccc dddd 1 00000001 0004 2

// ==== tests/tb_hyper_front.sv ====
`timescale 1ns/1ps

module tb_hyper_front import hyper_front_pkg::*; ();

    localparam int unsigned TimeoutCycles = 200;
    localparam logic [31:0] Seed          = 32'h67b3_d59e;

    logic       clk_i, rst_ni;
    logic       ar_valid_i, ar_ready_o, aw_valid_i, aw_ready_o;
    addr_t      ar_addr_i, aw_addr_i;
    len_t       ar_len_i, aw_len_i;
    size_t      ar_size_i, aw_size_i;
    burst_t     ar_burst_i, aw_burst_i;
    logic       w_valid_i, w_ready_o, w_last_i;
    word_t      w_data_i;
    strb_t      w_strb_i;
    logic       r_valid_o, r_ready_i, r_last_o;
    word_t      r_data_o;
    resp_t      r_resp_o;
    logic       b_valid_o, b_ready_i;
    resp_t      b_resp_o;
    logic       trans_valid_o, trans_ready_i, trans_write_o, trans_addr_space_o;
    addr_t      trans_addr_o;
    blen_t      trans_burst_o;
    cs_t        trans_cs_o;
    logic       tx_valid_o, tx_ready_i, tx_last_o;
    word_t      tx_data_o;
    strb_t      tx_strb_o;
    logic       rx_valid_i, rx_ready_o, rx_last_i, rx_error_i;
    word_t      rx_data_i;
    logic       b_phy_valid_i, b_phy_ready_o, b_error_i;
    logic [4:0] addr_mask_msb_i;
    logic       addr_space_i, trans_active_o;

    // Current golden line
    string       line, cur_name, kind;
    logic [31:0] g_addr, g_len, g_size, g_msb, g_strb, g_err;
    logic [31:0] exp_addr, exp_burst, exp_cs;
    word_t       words [4];
    int          n;

    int mismatches, timeouts, other_errors;

    hyper_front hyper_front_inst (.*);

    always #50 clk_i = ~clk_i;

    // ========================================
    // Reporting
    // ========================================

    task automatic finish_run();
        $display("Summary: %0d mismatches, %0d timeouts, %0d other errors",
                 mismatches, timeouts, other_errors);
        if (mismatches + timeouts + other_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    endtask

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            mismatches++;
            $display("mismatch %s %s: expected %h, actual %h", cur_name, what, exp, act);
        end
    endtask

    task automatic report_timeout(input string what);
        timeouts++;
        $display("Timeout: no %s within %0d cycles in test %s", what, TimeoutCycles, cur_name);
        finish_run();
    endtask

    task automatic check_tx_idle();
        assert (!tx_valid_o) else begin
            other_errors++;
            $display("tx_valid_o went high before the write descriptor in test %s", cur_name);
        end
    endtask

    // One transfer at a time
    always @(negedge clk_i) begin
        if (rst_ni) begin
            assert (!(trans_valid_o && trans_active_o)) else begin
                other_errors++;
                $display("Descriptor offered while a transfer is active in test %s", cur_name);
            end
        end
    end

    // ========================================
    // Master and PHY models
    // ========================================

    task automatic send_w_beats();
        int i;
        int cycles;
        for (i = 0; i < n; i++) begin
            @(posedge clk_i);
            w_valid_i <= 1'b1;
            w_data_i  <= words[i];
            w_strb_i  <= g_strb[1:0];
            w_last_i  <= (i == n - 1);
            cycles = 0;
            @(negedge clk_i);
            while (!w_ready_o) begin
                cycles++;
                if (cycles >= TimeoutCycles) report_timeout("w_ready_o");
                @(negedge clk_i);
            end
            check_tx_idle();
        end
        @(posedge clk_i);
        w_valid_i <= 1'b0;
        w_last_i  <= 1'b0;
    endtask

    // Both valids may rise together, the arbiter picks
    task automatic send_requests(input logic do_ar, input logic do_aw);
        int   cycles;
        logic ar_pending, aw_pending, ar_done, aw_done;
        ar_pending = do_ar;
        aw_pending = do_aw;
        cycles = 0;
        @(posedge clk_i);
        ar_valid_i <= do_ar;
        aw_valid_i <= do_aw;
        ar_addr_i  <= g_addr;
        aw_addr_i  <= g_addr;
        ar_len_i   <= g_len[7:0];
        aw_len_i   <= g_len[7:0];
        ar_size_i  <= g_size[2:0];
        aw_size_i  <= g_size[2:0];
        ar_burst_i <= BurstIncr;
        aw_burst_i <= BurstIncr;
        while (ar_pending || aw_pending) begin
            @(negedge clk_i);
            ar_done = ar_valid_i && ar_ready_o;
            aw_done = aw_valid_i && aw_ready_o;
            @(posedge clk_i);
            if (ar_done) begin
                ar_valid_i <= 1'b0;
                ar_pending = 1'b0;
            end
            if (aw_done) begin
                aw_valid_i <= 1'b0;
                aw_pending = 1'b0;
            end
            cycles++;
            if (cycles >= TimeoutCycles) report_timeout("AR or AW handshake");
        end
    endtask

    task automatic accept_descriptor(input logic exp_write);
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk_i);
            trans_ready_i <= ($urandom % 3) != 0;
            @(negedge clk_i);
            if (exp_write) check_tx_idle();
            cycles++;
            if (cycles >= TimeoutCycles) report_timeout("descriptor handshake");
        end while (!(trans_valid_o && trans_ready_i));
        check_value("trans_write_o", exp_write, trans_write_o);
        check_value("trans_addr_o", exp_addr, trans_addr_o);
        check_value("trans_burst_o", exp_burst, trans_burst_o);
        check_value("trans_cs_o", exp_cs, trans_cs_o);
        check_value("trans_addr_space_o", addr_space_i, trans_addr_space_o);
        @(posedge clk_i);
        trans_ready_i <= 1'b0;
    endtask

    task automatic feed_read();
        int i;
        int cycles;
        for (i = 0; i < n; i++) begin
            @(posedge clk_i);
            rx_valid_i <= 1'b1;
            rx_data_i  <= words[i];
            rx_last_i  <= (i == n - 1);
            rx_error_i <= g_err[0];
            cycles = 0;
            @(negedge clk_i);
            while (!rx_ready_o) begin
                cycles++;
                if (cycles >= TimeoutCycles) report_timeout("rx_ready_o");
                @(negedge clk_i);
            end
            check_value("trans_active_o", 1, trans_active_o);
            check_value("r_valid_o", 1, r_valid_o);
            check_value("r_data_o", words[i], r_data_o);
            check_value("r_last_o", i == n - 1, r_last_o);
            check_value("r_resp_o", g_err[0] ? RespSlvErr : RespOkay, r_resp_o);
        end
        @(posedge clk_i);
        rx_valid_i <= 1'b0;
        rx_last_i  <= 1'b0;
        rx_error_i <= 1'b0;
        @(negedge clk_i);
        check_value("trans_active_o after last R", 0, trans_active_o);
    endtask

    // PHY takes write words with random stalls
    task automatic collect_tx();
        int got;
        int cycles;
        got = 0;
        cycles = 0;
        while (got < n) begin
            @(posedge clk_i);
            tx_ready_i <= ($urandom % 4) != 0;
            @(negedge clk_i);
            if (tx_valid_o && tx_ready_i) begin
                check_value("tx_data_o", words[got], tx_data_o);
                check_value("tx_strb_o", g_strb[1:0], tx_strb_o);
                check_value("tx_last_o", got == n - 1, tx_last_o);
                got++;
            end
            cycles++;
            if (cycles >= TimeoutCycles) report_timeout("tx beat");
        end
        @(posedge clk_i);
        tx_ready_i <= 1'b0;
    endtask

    task automatic send_b();
        int cycles;
        cycles = 0;
        @(posedge clk_i);
        b_phy_valid_i <= 1'b1;
        b_error_i     <= g_err[0];
        @(negedge clk_i);
        while (!b_phy_ready_o) begin
            cycles++;
            if (cycles >= TimeoutCycles) report_timeout("b_phy_ready_o");
            @(negedge clk_i);
        end
        check_value("b_valid_o", 1, b_valid_o);
        check_value("b_resp_o", g_err[0] ? RespSlvErr : RespOkay, b_resp_o);
        check_value("trans_active_o before B", 1, trans_active_o);
        @(posedge clk_i);
        b_phy_valid_i <= 1'b0;
        b_error_i     <= 1'b0;
        @(negedge clk_i);
        check_value("trans_active_o after B", 0, trans_active_o);
    endtask

    task automatic run_line();
        n = int'(g_len) + 1;
        @(posedge clk_i);
        addr_mask_msb_i <= g_msb[4:0];
        // Address space flag varies per transaction
        addr_space_i    <= ($urandom % 2) != 0;
        if (kind == "rd") begin
            send_requests(1'b1, 1'b0);
            accept_descriptor(1'b0);
            feed_read();
        end else if (kind == "wr") begin
            send_w_beats();
            send_requests(1'b0, 1'b1);
            accept_descriptor(1'b1);
            collect_tx();
            send_b();
        end else if (kind == "rdwr") begin
            // Read goes first, the write waits for it
            send_w_beats();
            send_requests(1'b1, 1'b1);
            accept_descriptor(1'b0);
            feed_read();
            accept_descriptor(1'b1);
            collect_tx();
            send_b();
        end else begin
            other_errors++;
            $display("Unknown transaction kind %s in test %s", kind, cur_name);
        end
    endtask

    // ========================================
    // Main sequence
    // ========================================

    initial begin
        int fd;
        int fields;
        int i;
        clk_i = 1'b0;
        rst_ni = 1'b0;
        ar_valid_i = 1'b0;
        ar_addr_i = '0;
        ar_len_i = '0;
        ar_size_i = '0;
        ar_burst_i = BurstIncr;
        aw_valid_i = 1'b0;
        aw_addr_i = '0;
        aw_len_i = '0;
        aw_size_i = '0;
        aw_burst_i = BurstIncr;
        w_valid_i = 1'b0;
        w_data_i = '0;
        w_strb_i = '0;
        w_last_i = 1'b0;
        r_ready_i = 1'b1;
        b_ready_i = 1'b1;
        trans_ready_i = 1'b0;
        tx_ready_i = 1'b0;
        rx_valid_i = 1'b0;
        rx_data_i = '0;
        rx_last_i = 1'b0;
        rx_error_i = 1'b0;
        b_phy_valid_i = 1'b0;
        b_error_i = 1'b0;
        addr_mask_msb_i = 5'd23;
        addr_space_i = 1'b0;
        mismatches = 0;
        timeouts = 0;
        other_errors = 0;
        cur_name = "reset";
        void'($urandom(Seed));

        // Outputs stay quiet in reset and on the first cycle out of it
        for (i = 0; i < 6; i++) begin
            if (i == 5) begin
                @(posedge clk_i);
                rst_ni <= 1'b1;
            end
            @(negedge clk_i);
            check_value("trans_valid_o", 0, trans_valid_o);
            check_value("tx_valid_o", 0, tx_valid_o);
            check_value("trans_active_o", 0, trans_active_o);
        end

        fd = $fopen("tests/hyper_front_golden.txt", "r");
        if (fd == 0) begin
            other_errors++;
            $display("Cannot open the golden data file");
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() < 2 || line.getc(0) == "#") continue;
                fields = $sscanf(line, "%s %s %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                 cur_name, kind, g_addr, g_len, g_size, g_msb, g_strb,
                                 words[0], words[1], words[2], words[3], g_err,
                                 exp_addr, exp_burst, exp_cs);
                if (fields != 15) begin
                    other_errors++;
                    $display("Malformed golden line: %s", line);
                end else begin
                    run_line();
                end
            end
            $fclose(fd);
        end
        finish_run();
    end

endmodule
